//--- Makefile
TOOL     := verilator
FLAGS    := --binary --assert --no-stop-fail -j 0
TOP      := tb_window_filter
FILELIST := list.f
SIM      := obj_dir/V$(TOP)
PASS_MSG := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
  parameter int K    = 3,
  parameter int COLS = 8
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     advance_i,
  input  win_pkg::pixel_t          pix_i,
  output win_pkg::pixel_t [K-1:0]  column_o
);

  // k-1 rows of delay laid end to end in one shift chain.
  localparam int DEPTH = (K - 1) * COLS;

  win_pkg::pixel_t [DEPTH-1:0] chain_q;

  ////////////////////////////////////////////////////////////
  // row delay chain
  ////////////////////////////////////////////////////////////

  // element 0 always holds the most recently accepted pixel.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      chain_q <= '0;
    end else if (advance_i) begin
      chain_q <= {chain_q[DEPTH-2:0], pix_i};
    end
  end

  ////////////////////////////////////////////////////////////
  // vertical taps
  ////////////////////////////////////////////////////////////

  // the incoming pixel is the bottom of the column.
  assign column_o[0] = pix_i;

  // pixels arrive without gaps in raster order, so a tap placed
  // j*COLS beats back sits exactly j rows above the incoming pixel.
  for (genvar j = 1; j < K; j++) begin : g_tap
    assign column_o[j] = chain_q[j*COLS-1];
  end

endmodule

//--- list.f
win_pkg.sv
line_buffer.sv
window_buffer.sv
window_reduce.sv
stream_ctrl.sv
window_filter_top.sv
window_filter_props.sv
tb_window_filter.sv

//--- stream_ctrl.sv
`timescale 1ns/1ps

module stream_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic in_req_i,
  input  logic window_ok_i,
  input  logic res_valid_i,
  input  logic out_ack_i,
  output logic in_ack_o,
  output logic advance_o,
  output logic load_o,
  output logic out_req_o
);

  win_pkg::ctrl_state_e state_q;
  win_pkg::ctrl_state_e ret_state;

  // set when a result is on its way and cleared once the sink takes it.
  logic res_pend_q;

  // a pixel is taken only from idle, so each request advances once.
  assign advance_o = (state_q == win_pkg::st_idle) && in_req_i;

  // st_accept is the cycle right after the advance.
  assign load_o = (state_q == win_pkg::st_accept) && window_ok_i;

  // where to go once the input handshake has closed.
  always_comb begin
    if (res_pend_q || load_o) begin
      ret_state = win_pkg::st_out_req;
    end else if (out_ack_i) begin
      ret_state = win_pkg::st_wait_ack_low;
    end else begin
      ret_state = win_pkg::st_idle;
    end
  end

  ////////////////////////////////////////////////////////////
  // input handshake FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= win_pkg::st_idle;
      in_ack_o <= 1'b0;
    end else begin
      case (state_q)
        win_pkg::st_idle: begin
          if (in_req_i) begin
            in_ack_o <= 1'b1;
            state_q  <= win_pkg::st_accept;
          end
        end
        win_pkg::st_accept, win_pkg::st_wait_req_low: begin
          if (!in_req_i) begin
            in_ack_o <= 1'b0;
            state_q  <= ret_state;
          end else begin
            state_q <= win_pkg::st_wait_req_low;
          end
        end
        win_pkg::st_out_req: begin
          if (!res_pend_q) begin
            state_q <= win_pkg::st_wait_ack_low;
          end
        end
        win_pkg::st_wait_ack_low: begin
          if (!out_ack_i) begin
            state_q <= win_pkg::st_idle;
          end
        end
        default: state_q <= win_pkg::st_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // output handshake
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_pend_q <= 1'b0;
      out_req_o  <= 1'b0;
    end else begin
      if (load_o) begin
        res_pend_q <= 1'b1;
      end else if (out_req_o && out_ack_i) begin
        res_pend_q <= 1'b0;
      end
      if (res_valid_i) begin
        out_req_o <= 1'b1;
      end else if (out_ack_i) begin
        out_req_o <= 1'b0;
      end
    end
  end

endmodule

//--- tb_window_filter.sv
`timescale 1ns/1ps

module tb_window_filter;

  localparam int K             = 3;
  localparam int COLS          = 8;
  localparam int ROWS          = 6;
  localparam int CW            = win_pkg::coord_w;
  localparam int RW            = win_pkg::res_w;
  localparam int RES_PER_FRAME = (ROWS - K + 1) * (COLS - K + 1);
  localparam int CLK_NS        = 4;
  localparam int FRAMES        = 7;
  localparam int TIMEOUT_NS    = FRAMES * ROWS * COLS * 40 * CLK_NS;

  logic              clk;
  logic              rst_n;
  logic              in_req;
  win_pkg::pix_in_t  in_data;
  logic              in_ack;
  logic              out_req;
  win_pkg::res_out_t out_data;
  logic              out_ack;

  // model of the frame being sent.
  logic [win_pkg::pix_w-1:0] img [ROWS][COLS];

  win_pkg::res_out_t exp_q[$];
  logic [31:0]       src_state;
  logic [31:0]       sink_state;
  string             test_name;
  int                res_count;
  logic              sink_busy;

  window_filter_top #(.K(K), .COLS(COLS), .ROWS(ROWS)) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_req_i   (in_req),
    .in_data_i  (in_data),
    .out_ack_i  (out_ack),
    .in_ack_o   (in_ack),
    .out_req_o  (out_req),
    .out_data_o (out_data)
  );

  bind window_filter_top window_filter_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_req_i   (in_req_i),
    .in_data_i  (in_data_i),
    .in_ack_i   (in_ack_o),
    .out_req_i  (out_req_o),
    .out_data_i (out_data_o),
    .out_ack_i  (out_ack_i)
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic win_pkg::op_e pick_op(input logic [31:0] s);
    case (s[31:24] % 8'd3)
      8'd0:    return win_pkg::op_sum;
      8'd1:    return win_pkg::op_max;
      default: return win_pkg::op_min;
    endcase
  endfunction

  // reduces the K x K block of the model ending at row r, column c.
  function automatic logic [RW-1:0] window_value(input win_pkg::op_e op, input int r,
                                                 input int c);
    int sum;
    int mx;
    int mn;
    int p;
    sum = 0;
    mx  = 0;
    mn  = (1 << win_pkg::pix_w) - 1;
    for (int i = r - K + 1; i <= r; i++) begin
      for (int j = c - K + 1; j <= c; j++) begin
        p   = int'(img[i][j]);
        sum = sum + p;
        if (p > mx) mx = p;
        if (p < mn) mn = p;
      end
    end
    case (op)
      win_pkg::op_max: return RW'(mx);
      win_pkg::op_min: return RW'(mn);
      default:         return RW'(sum);
    endcase
  endfunction

  task automatic check_field(input string field, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("error %s %s: expected %0d actual %0d", test_name, field, expected, actual);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  task automatic take_result();
    win_pkg::res_out_t exp;
    if (exp_q.size() == 0) begin
      $display("result at row %0d col %0d arrived with no window pending in %s",
               out_data.row, out_data.col, test_name);
      $display("Finished with errors");
      $fatal(1);
    end else begin
      exp = exp_q.pop_front();
      check_field("value", int'(exp.value), int'(out_data.value));
      check_field("row", int'(exp.row), int'(out_data.row));
      check_field("col", int'(exp.col), int'(out_data.col));
      check_field("last", int'(exp.last), int'(out_data.last));
      res_count++;
    end
  endtask

  task automatic send_pixel(input win_pkg::pixel_t pix, input win_pkg::op_e op);
    @(negedge clk);
    in_data.pix = pix;
    in_data.op  = op;
    in_req      = 1'b1;
    @(negedge clk);
    while (!in_ack) @(negedge clk);
    in_req = 1'b0;
    @(negedge clk);
    while (in_ack) @(negedge clk);
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (exp_q.size() != 0 || sink_busy || out_req) @(negedge clk);
    // a few quiet cycles expose any duplicate result.
    repeat (4) @(negedge clk);
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // sends the first npix pixels of a frame, all with op unless mixed.
  task automatic send_frame(input string name, input win_pkg::op_e op, input logic mixed,
                            input int npix);
    win_pkg::res_out_t exp;
    win_pkg::op_e      pix_op;
    win_pkg::pixel_t   pix;
    int                start;
    int                pushed;
    int                r;
    int                c;
    test_name = name;
    start     = res_count;
    pushed    = 0;
    for (int n = 0; n < npix; n++) begin
      r         = n / COLS;
      c         = n % COLS;
      src_state = lcg_step(src_state);
      pix       = src_state[23:16];
      pix_op    = mixed ? pick_op(src_state) : op;
      img[r][c] = pix;
      if (r >= K - 1 && c >= K - 1) begin
        exp.value = window_value(pix_op, r, c);
        exp.row   = CW'(r);
        exp.col   = CW'(c);
        exp.last  = (r == ROWS - 1) && (c == COLS - 1);
        exp_q.push_back(exp);
        pushed++;
      end
      send_pixel(pix, pix_op);
    end
    wait_drain();
    check_field("result count", (npix == ROWS * COLS) ? RES_PER_FRAME : pushed,
                res_count - start);
  endtask

  ////////////////////////////////////////////////////////////
  // clock, sink, watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // output side with a random delay before each ack.
  initial begin
    sink_state = 32'h684e;
    out_ack    = 1'b0;
    sink_busy  = 1'b0;
    res_count  = 0;
    forever begin
      @(negedge clk);
      if (out_req && rst_n) begin
        sink_busy = 1'b1;
        take_result();
        sink_state = lcg_step(sink_state);
        repeat (sink_state[17:16]) @(negedge clk);
        out_ack = 1'b1;
        while (out_req) @(negedge clk);
        out_ack   = 1'b0;
        sink_busy = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (dut_i.u_props.fail_cnt != 0) begin
      $display("a handshake property failed during %s", test_name);
      $display("Finished with errors");
      $fatal(1);
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not complete within %0d ns", TIMEOUT_NS);
    $display("Finished with errors");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n     = 1'b0;
    in_req    = 1'b0;
    in_data   = '0;
    src_state = 32'h684e;
    test_name = "reset";
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // two sum frames back to back show that the counters wrap.
    send_frame("sum_frame_a", win_pkg::op_sum, 1'b0, ROWS * COLS);
    send_frame("sum_frame_b", win_pkg::op_sum, 1'b0, ROWS * COLS);
    send_frame("max_frame", win_pkg::op_max, 1'b0, ROWS * COLS);
    send_frame("min_frame", win_pkg::op_min, 1'b0, ROWS * COLS);
    send_frame("mixed_frame", win_pkg::op_sum, 1'b1, ROWS * COLS);

    // stop partway through a frame, reset, and start over at (0,0).
    send_frame("reset_mid_frame", win_pkg::op_sum, 1'b0, 3 * COLS + 5);
    apply_reset();
    send_frame("after_reset", win_pkg::op_sum, 1'b1, ROWS * COLS);

    if (dut_i.u_props.fail_cnt == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1);
    end
  end

endmodule

//--- win_pkg.sv
package win_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int pix_w = 8;
  localparam int coord_w = 10;

  // holds a full sum over a 5x5 window of 8-bit pixels.
  localparam int res_w = 16;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic [pix_w-1:0] pixel_t;

  typedef enum logic [1:0] {
    op_sum,
    op_max,
    op_min
  } op_e;

  // one input beat: the pixel and the reduction it asks for.
  typedef struct packed {
    op_e    op;
    pixel_t pix;
  } pix_in_t;

  // one reduced window, tagged with the position of its newest pixel.
  typedef struct packed {
    logic [res_w-1:0]   value;
    logic [coord_w-1:0] row;
    logic [coord_w-1:0] col;
    logic               last;
  } res_out_t;

  typedef enum logic [2:0] {
    st_idle,
    st_accept,
    st_wait_req_low,
    st_out_req,
    st_wait_ack_low
  } ctrl_state_e;

endpackage

//--- window_buffer.sv
`timescale 1ns/1ps

module window_buffer #(
  parameter int K    = 3,
  parameter int COLS = 8,
  parameter int ROWS = 6
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 advance_i,
  input  win_pkg::op_e                         op_i,
  input  win_pkg::pixel_t [K-1:0]              column_i,
  output win_pkg::pixel_t [K-1:0][K-1:0]       window_o,
  output win_pkg::op_e                         op_o,
  output logic                                 window_ok_o,
  output logic [win_pkg::coord_w-1:0]          row_o,
  output logic [win_pkg::coord_w-1:0]          col_o,
  output logic                                 last_o
);

  localparam int CW = win_pkg::coord_w;

  // win_q[r][c] is r rows above and c columns left of the newest pixel.
  win_pkg::pixel_t [K-1:0][K-1:0] win_q;

  // position of the pixel that the next advance will accept.
  logic [CW-1:0] col_q;
  logic [CW-1:0] row_q;
  logic [CW-1:0] col_inc;
  logic [CW-1:0] row_inc;
  logic          col_wrap;
  logic          row_wrap;

  assign col_inc  = col_q + 1'b1;
  assign row_inc  = row_q + 1'b1;
  assign col_wrap = (col_q == CW'(COLS - 1));
  assign row_wrap = (row_q == CW'(ROWS - 1));

  ////////////////////////////////////////////////////////////
  // counters and window array
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q       <= '0;
      row_q       <= '0;
      win_q       <= '0;
      window_ok_o <= 1'b0;
      last_o      <= 1'b0;
    end else if (advance_i) begin
      col_q <= col_wrap ? '0 : col_inc;
      if (col_wrap) begin
        row_q <= row_wrap ? '0 : row_inc;
      end
      for (int r = 0; r < K; r++) begin
        win_q[r] <= {win_q[r][K-2:0], column_i[r]};
      end
      // full window once k rows and k columns have been seen.
      window_ok_o <= (row_q >= CW'(K - 1)) && (col_q >= CW'(K - 1));
      last_o      <= row_wrap && col_wrap;
    end
  end

  // tags of the accepted pixel, held until the next advance.
  always_ff @(posedge clk) begin
    if (advance_i) begin
      op_o  <= op_i;
      row_o <= row_q;
      col_o <= col_q;
    end
  end

  assign window_o = win_q;

endmodule

//--- window_filter_props.sv
`timescale 1ns/1ps

module window_filter_props (
  input logic              clk,
  input logic              rst_n,
  input logic              in_req_i,
  input win_pkg::pix_in_t  in_data_i,
  input logic              in_ack_i,
  input logic              out_req_i,
  input win_pkg::res_out_t out_data_i,
  input logic              out_ack_i
);

  // number of property failures, watched by the testbench.
  int fail_cnt = 0;

  // both links are quiet on the cycle after a reset edge.
  reset_quiet: assert property (@(posedge clk) !rst_n |=> !in_ack_i && !out_req_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("links not quiet after reset");
    end

  ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(in_ack_i) |-> $past(in_req_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("input ack rose without req");
    end

  ack_drops_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(in_ack_i) |-> $past(!in_req_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("input ack fell while req high");
    end

  // the source holds req and data until it sees ack.
  src_hold: assert property (@(posedge clk) disable iff (!rst_n)
    in_req_i && !in_ack_i |=> in_ack_i || (in_req_i && $stable(in_data_i)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("input req or data moved before ack");
    end

  // no new pixel is taken while the output link is busy.
  no_ack_out_busy: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(in_ack_i) |-> !out_req_i && $past(!out_req_i && !out_ack_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("input ack rose during output handshake");
    end

  out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_req_i && !out_ack_i |=> out_req_i && $stable(out_data_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("output req or data moved before ack");
    end

  out_drops_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(out_req_i) |-> $past(out_ack_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("output req fell without ack");
    end

endmodule

//--- window_filter_top.sv
`timescale 1ns/1ps

module window_filter_top #(
  parameter int K    = 3,
  parameter int COLS = 8,
  parameter int ROWS = 6
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_req_i,
  input  win_pkg::pix_in_t    in_data_i,
  input  logic                out_ack_i,
  output logic                in_ack_o,
  output logic                out_req_o,
  output win_pkg::res_out_t   out_data_o
);

  logic                             advance;
  logic                             load;
  logic                             window_ok;
  logic                             res_valid;
  win_pkg::pixel_t [K-1:0]          column;
  win_pkg::pixel_t [K-1:0][K-1:0]   window;
  win_pkg::op_e                     win_op;
  logic [win_pkg::coord_w-1:0]      win_row;
  logic [win_pkg::coord_w-1:0]      win_col;
  logic                             win_last;

  stream_ctrl u_stream_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_req_i    (in_req_i),
    .window_ok_i (window_ok),
    .res_valid_i (res_valid),
    .out_ack_i   (out_ack_i),
    .in_ack_o    (in_ack_o),
    .advance_o   (advance),
    .load_o      (load),
    .out_req_o   (out_req_o)
  );

  line_buffer #(.K(K), .COLS(COLS)) u_line_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .advance_i (advance),
    .pix_i     (in_data_i.pix),
    .column_o  (column)
  );

  window_buffer #(.K(K), .COLS(COLS), .ROWS(ROWS)) u_window_buffer (
    .clk         (clk),
    .rst_n       (rst_n),
    .advance_i   (advance),
    .op_i        (in_data_i.op),
    .column_i    (column),
    .window_o    (window),
    .op_o        (win_op),
    .window_ok_o (window_ok),
    .row_o       (win_row),
    .col_o       (win_col),
    .last_o      (win_last)
  );

  window_reduce #(.K(K)) u_window_reduce (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_i      (load),
    .window_i    (window),
    .op_i        (win_op),
    .row_i       (win_row),
    .col_i       (win_col),
    .last_i      (win_last),
    .res_o       (out_data_o),
    .res_valid_o (res_valid)
  );

endmodule

//--- window_reduce.sv
`timescale 1ns/1ps

module window_reduce #(
  parameter int K = 3
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 load_i,
  input  win_pkg::pixel_t [K-1:0][K-1:0]       window_i,
  input  win_pkg::op_e                         op_i,
  input  logic [win_pkg::coord_w-1:0]          row_i,
  input  logic [win_pkg::coord_w-1:0]          col_i,
  input  logic                                 last_i,
  output win_pkg::res_out_t                    res_o,
  output logic                                 res_valid_o
);

  localparam int RW = win_pkg::res_w;

  logic [RW-1:0]   acc_sum;
  win_pkg::pixel_t acc_max;
  win_pkg::pixel_t acc_min;
  logic [RW-1:0]   value;

  ////////////////////////////////////////////////////////////
  // reduction over the whole window
  ////////////////////////////////////////////////////////////

  always_comb begin
    acc_sum = '0;
    acc_max = '0;
    acc_min = '1;
    for (int r = 0; r < K; r++) begin
      for (int c = 0; c < K; c++) begin
        acc_sum = acc_sum + RW'(window_i[r][c]);
        if (window_i[r][c] > acc_max) begin
          acc_max = window_i[r][c];
        end
        if (window_i[r][c] < acc_min) begin
          acc_min = window_i[r][c];
        end
      end
    end
  end

  // max and min are zero extended into the result field.
  always_comb begin
    case (op_i)
      win_pkg::op_max: value = RW'(acc_max);
      win_pkg::op_min: value = RW'(acc_min);
      default:         value = acc_sum;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // result register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= load_i;
    end
  end

  always_ff @(posedge clk) begin
    if (load_i) begin
      res_o.value <= value;
      res_o.row   <= row_i;
      res_o.col   <= col_i;
      res_o.last  <= last_i;
    end
  end

endmodule
